// ==== common/fetch_pkg.sv ====
package fetch_pkg;

	// byte address on the fetch bus
	parameter int addr_w = 32;

	// one instruction word, an instruction is one or two of these
	parameter int word_w = 32;

	parameter int word_bytes = word_w / 8; // address step between words

	// request from the fetch unit to the instruction memory
	typedef struct packed {
		logic cyc; // read request, accepted when stall is low
		logic [addr_w-1:0] adr;
	} fetch_req_t;

	// response from the instruction memory
	typedef struct packed {
		logic stall; // no read is accepted in this cycle
		logic ack; // dat is valid, one cycle after the accepted read
		logic [word_w-1:0] dat;
	} fetch_rsp_t;

	// load port used to fill the instruction memory
	typedef struct packed {
		logic we;
		logic [addr_w-1:0] adr;
		logic [word_w-1:0] dat;
	} mem_load_t;

	// assembled instruction
	// the second word of a two-word instruction sits in the high half
	// and a one-word instruction leaves the high half at zero
	// all zero means there is no instruction this cycle
	typedef logic [2*word_w-1:0] ir_t;

endpackage

// ==== fetch/fetch_fifo.sv ====
module fetch_fifo #(
	parameter int depth_log = 2,
	parameter type payload_t = logic [31:0]
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               flush_i,
	input  logic               push_i,
	input  payload_t           data_i,
	input  logic               pop_i,
	output payload_t           data_o,
	output logic [depth_log:0] count_o,
	output logic               empty_o
);

	localparam int depth = 2 ** depth_log;
	localparam logic [depth_log:0] full_count = (depth_log + 1)'(depth);

	payload_t mem [depth];

	logic [depth_log-1:0] rd_ptr;
	logic [depth_log-1:0] wr_ptr;
	logic [depth_log:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == full_count);
	assign do_pop = pop_i && (count != '0);

	// a push into a full queue only fits if a word leaves in the same cycle
	assign do_push = push_i && (!full || do_pop);

	assign data_o = mem[rd_ptr]; // head word is visible before it is popped
	assign count_o = count;
	assign empty_o = (count == '0);

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else if (flush_i)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps with the power of two depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (do_push && !flush_i)
			mem[wr_ptr] <= data_i;
	end

endmodule

// ==== fetch/ifetch.sv ====
module ifetch #(
	parameter int depth_log = 2
) (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic                          pc_set_i,
	input  logic [fetch_pkg::addr_w-1:0]  pc_in_i,
	input  logic                          stall_i,
	output fetch_pkg::fetch_req_t         req_o,
	input  fetch_pkg::fetch_rsp_t         rsp_i,
	output fetch_pkg::ir_t                ir_o,
	output logic [fetch_pkg::addr_w-1:0]  pc_o
);

	typedef enum logic [1:0] {
		st_restart,
		st_first,
		st_second
	} state_t;

	// queue depth, one bit wider than the counters so the sum cannot wrap
	localparam logic [depth_log+1:0] credit_lim = (depth_log + 2)'(2 ** depth_log);
	localparam logic [fetch_pkg::addr_w-1:0] step = fetch_pkg::addr_w'(fetch_pkg::word_bytes);
	localparam logic [depth_log:0] one_cnt = (depth_log + 1)'(1);

	state_t state;
	state_t state_next;

	logic [fetch_pkg::addr_w-1:0] bus_adr;
	logic [fetch_pkg::addr_w-1:0] bus_adr_next;
	logic [fetch_pkg::addr_w-1:0] pc_next;
	logic [fetch_pkg::word_w-1:0] low;
	logic [fetch_pkg::word_w-1:0] low_next;
	fetch_pkg::ir_t ir_next;

	logic [depth_log:0] outstanding;
	logic [depth_log:0] outstanding_next;
	logic [depth_log:0] drop_cnt;
	logic [depth_log:0] drop_next;

	logic [depth_log:0] q_count;
	logic [fetch_pkg::word_w-1:0] q_word;
	logic q_empty;
	logic q_push;
	logic q_pop;

	logic credit_ok;
	logic accept;

	// queued words plus reads still in flight must stay within the queue
	assign credit_ok = ({1'b0, q_count} + {1'b0, outstanding}) < credit_lim;

	assign req_o.cyc = (state != st_restart) && !pc_set_i && credit_ok;
	assign req_o.adr = bus_adr;
	assign accept = req_o.cyc && !rsp_i.stall;

	// acks still owed to the path before a redirect never reach the queue
	assign q_push = rsp_i.ack && (drop_cnt == '0) && !pc_set_i;

	assign q_pop = (state != st_restart) && !stall_i && !q_empty && !pc_set_i;

	fetch_fifo #(
		.depth_log (depth_log),
		.payload_t (logic [fetch_pkg::word_w-1:0])
	) u_fifo (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.flush_i (pc_set_i),
		.push_i  (q_push),
		.data_i  (rsp_i.dat),
		.pop_i   (q_pop),
		.data_o  (q_word),
		.count_o (q_count),
		.empty_o (q_empty)
	);

	// bus side: address generation and read accounting
	always_comb
	begin
		bus_adr_next = bus_adr;
		if (pc_set_i)
			bus_adr_next = pc_in_i;
		else if (accept)
			bus_adr_next = bus_adr + step;

		outstanding_next = outstanding;
		case ({accept, rsp_i.ack})
			2'b10: outstanding_next = outstanding + one_cnt;
			2'b01: outstanding_next = outstanding - one_cnt;
			default: outstanding_next = outstanding;
		endcase

		drop_next = drop_cnt;
		if (pc_set_i)
		begin
			// every read still in flight belongs to the old path
			drop_next = rsp_i.ack ? (outstanding - one_cnt) : outstanding;
		end
		else if (rsp_i.ack && (drop_cnt != '0))
			drop_next = drop_cnt - one_cnt;
	end

	// instruction side: assembly FSM and program counter
	always_comb
	begin
		state_next = state;
		pc_next = pc_o;
		low_next = low;
		ir_next = '0; // an instruction is shown for one cycle only

		case (state)
			st_restart:
				state_next = st_first;
			st_first:
				if (q_pop)
				begin
					pc_next = pc_o + step;
					if (q_word[0])
					begin
						low_next = q_word; // wait for the second word
						state_next = st_second;
					end
					else
						ir_next = {{fetch_pkg::word_w{1'b0}}, q_word};
				end
			st_second:
				if (q_pop)
				begin
					pc_next = pc_o + step;
					ir_next = {q_word, low};
					state_next = st_first;
				end
			default:
				state_next = st_restart;
		endcase

		if (pc_set_i)
		begin
			pc_next = pc_in_i;
			state_next = st_restart;
		end
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			state <= st_restart;
			pc_o <= '0;
			ir_o <= '0;
			bus_adr <= '0;
			outstanding <= '0;
			drop_cnt <= '0;
		end
		else
		begin
			state <= state_next;
			pc_o <= pc_next;
			ir_o <= ir_next;
			bus_adr <= bus_adr_next;
			outstanding <= outstanding_next;
			drop_cnt <= drop_next;
		end
	end

	always_ff @(posedge clk_i)
	begin
		low <= low_next;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run from the project root so the tests file path resolves
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_fetch -o tb_fetch
./obj_dir/tb_fetch > sim.log 2>&1
cat sim.log
if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi

// ==== source/fetch_top.sv ====
module fetch_top #(
	parameter int fifo_depth_log = 2,
	parameter int mem_depth_log = 6
) (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic                          pc_set_i,
	input  logic [fetch_pkg::addr_w-1:0]  pc_in_i,
	input  logic                          stall_i,
	input  fetch_pkg::mem_load_t          load_i,
	output fetch_pkg::ir_t                ir_o,
	output logic [fetch_pkg::addr_w-1:0]  pc_o
);

	fetch_pkg::fetch_req_t bus_req;
	fetch_pkg::fetch_rsp_t bus_rsp;

	ifetch #(
		.depth_log (fifo_depth_log)
	) u_ifetch (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.pc_set_i (pc_set_i),
		.pc_in_i  (pc_in_i),
		.stall_i  (stall_i),
		.req_o    (bus_req),
		.rsp_i    (bus_rsp),
		.ir_o     (ir_o),
		.pc_o     (pc_o)
	);

	// instruction memory is the only slave on the fetch bus
	inst_mem #(
		.depth_log (mem_depth_log)
	) u_mem (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.req_i  (bus_req),
		.rsp_o  (bus_rsp),
		.load_i (load_i)
	);

endmodule

// ==== source/inst_mem.sv ====
module inst_mem #(
	parameter int depth_log = 6
) (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  fetch_pkg::fetch_req_t req_i,
	output fetch_pkg::fetch_rsp_t rsp_o,
	input  fetch_pkg::mem_load_t  load_i
);

	localparam int depth = 2 ** depth_log;
	localparam int idx_lsb = $clog2(fetch_pkg::word_bytes); // byte offset bits

	logic [fetch_pkg::word_w-1:0] mem [depth];

	logic load_pend;
	logic [depth_log-1:0] load_idx;
	logic [fetch_pkg::word_w-1:0] load_dat;

	logic [depth_log-1:0] rd_idx;
	logic [fetch_pkg::word_w-1:0] rd_dat;
	logic accept;
	logic ack;

	// upper address bits are ignored so fetching past the end wraps to word 0
	assign rd_idx = req_i.adr[idx_lsb +: depth_log];

	// a waiting load owns the array for this cycle
	assign accept = req_i.cyc && !load_pend;

	assign rsp_o.stall = load_pend;
	assign rsp_o.ack = ack;
	assign rsp_o.dat = rd_dat;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			load_pend <= 1'b0;
			ack <= 1'b0;
		end
		else
		begin
			load_pend <= load_i.we;
			ack <= accept; // one cycle after acceptance, in order
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (load_i.we)
		begin
			load_idx <= load_i.adr[idx_lsb +: depth_log];
			load_dat <= load_i.dat;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (load_pend)
			mem[load_idx] <= load_dat;
		if (accept)
			rd_dat <= mem[rd_idx];
	end

endmodule

// ==== src.f ====
common/fetch_pkg.sv
fetch/fetch_fifo.sv
fetch/ifetch.sv
source/inst_mem.sv
source/fetch_top.sv
testbench/fetch_checker.sv
testbench/tb_fetch.sv

// ==== testbench/fetch_checker.sv ====
module fetch_checker (
	input  logic                         clk_i,
	input  logic                         rst_i,
	input  fetch_pkg::ir_t               ir_i,
	input  logic [fetch_pkg::addr_w-1:0] pc_i,
	input  logic [127:0]                 name_i,
	input  int                           end_i,
	input  fetch_pkg::ir_t               exp_ir_i,
	input  logic [fetch_pkg::addr_w-1:0] exp_pc_i,
	output int                           idx_o,
	output int                           pass_o,
	output int                           fail_o
);

	int n_bad;
	int n_seen; // instructions compared in the running test

	// registered outputs are stable at the falling edge
	always @(negedge clk_i)
	begin
		if (rst_i)
		begin
			idx_o = 0;
			pass_o = 0;
			fail_o = 0;
			n_bad = 0;
			n_seen = 0;
		end
		else if (ir_i != '0 && idx_o < end_i)
		begin
			if (ir_i !== exp_ir_i || pc_i !== exp_pc_i)
			begin
				$display("Error %0s: instruction %0d expected ir %h pc %h, actual ir %h pc %h",
					name_i, n_seen, exp_ir_i, exp_pc_i, ir_i, pc_i);
				n_bad = n_bad + 1;
			end
			idx_o = idx_o + 1;
			n_seen = n_seen + 1;
			if (idx_o == end_i)
			begin
				if (n_bad == 0)
				begin
					$display("test %0s: pass, %0d instructions", name_i, n_seen);
					pass_o = pass_o + 1;
				end
				else
				begin
					$display("test %0s: fail, %0d of %0d instructions wrong", name_i, n_bad,
						n_seen);
					fail_o = fail_o + 1;
				end
				n_bad = 0;
				n_seen = 0;
			end
		end
	end

endmodule

// ==== testbench/fetch_tests.txt ====
# load <count>, then <count> pairs of byte address and word, all hex
# test <name> <target> <stall mask> <gap 0-7> <n expected> <n writes>, write pairs, then ir pc pairs
load 12
00 10000000  04 10000004  08 10000008  0c 2000000d
10 30000010  14 10000014  18 20000019  1c 3000001c
20 10000020  f4 200000f5  f8 300000f8  fc 100000fc
test seq_from_zero 00 00000000 0 3 0
10000000 04  10000004 08  10000008 0c
test two_word 0c 00000000 0 2 0
300000102000000d 14  10000014 18
test redirect_pair 18 0000aaaa 0 2 0
3000001c20000019 20  10000020 24
test random_stall 00 0f00f0f0 4 6 0
10000000 04  10000004 08  10000008 0c
300000102000000d 14  10000014 18  3000001c20000019 20
test load_writes 00 00000000 1 6 4
80 aaaa0080  84 aaaa0084  88 aaaa0088  8c aaaa008c
10000000 04  10000004 08  10000008 0c
300000102000000d 14  10000014 18  3000001c20000019 20
test addr_wrap f4 00000000 0 4 0
300000f8200000f5 fc  100000fc 100  10000000 104  10000004 108

// ==== testbench/tb_fetch.sv ====
module tb_fetch;

	localparam int max_tests = 16;
	localparam int max_words = 128;

	logic clk_i;
	logic rst_i;
	logic pc_set_i;
	logic [fetch_pkg::addr_w-1:0] pc_in_i;
	logic stall_i;
	fetch_pkg::mem_load_t load_i;
	fetch_pkg::ir_t ir_o;
	logic [fetch_pkg::addr_w-1:0] pc_o;

	// program words, write pairs and expected stream, all read from the tests file
	logic [31:0] load_adr [max_words];
	logic [31:0] load_dat [max_words];
	logic [31:0] wr_adr [max_words];
	logic [31:0] wr_dat [max_words];
	fetch_pkg::ir_t exp_ir [max_words];
	logic [31:0] exp_pc [max_words];
	logic [127:0] t_name [max_tests];
	logic [31:0] t_target [max_tests];
	logic [31:0] t_mask [max_tests];
	int t_gap [max_tests];
	int t_wr_start [max_tests];
	int t_wr_end [max_tests];
	int t_exp_end [max_tests];
	int n_load;
	int n_wr;
	int n_exp;
	int n_tests;
	logic file_ok;
	logic parse_bad;

	logic [127:0] cur_name;
	int cur_end; // checker compares while its index is below this
	int chk_idx;
	int n_pass;
	int n_fail;
	int cycles;
	int cycle_limit;

	fetch_pkg::ir_t exp_ir_now;
	logic [31:0] exp_pc_now;

	assign exp_ir_now = exp_ir[chk_idx];
	assign exp_pc_now = exp_pc[chk_idx];

	fetch_top #(
		.fifo_depth_log (2),
		.mem_depth_log  (6)
	) DUT (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.pc_set_i (pc_set_i),
		.pc_in_i  (pc_in_i),
		.stall_i  (stall_i),
		.load_i   (load_i),
		.ir_o     (ir_o),
		.pc_o     (pc_o)
	);

	fetch_checker u_checker (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.ir_i     (ir_o),
		.pc_i     (pc_o),
		.name_i   (cur_name),
		.end_i    (cur_end),
		.exp_ir_i (exp_ir_now),
		.exp_pc_i (exp_pc_now),
		.idx_o    (chk_idx),
		.pass_o   (n_pass),
		.fail_o   (n_fail)
	);

	always #20 clk_i = ~clk_i;

	always @(posedge clk_i)
	begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("timeout after %0d cycles, %0d of %0d expected instructions seen",
				cycles, chk_idx, n_exp);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic read_tests;
		int fd;
		int code;
		int cnt;
		int ne;
		int nw;
		logic short_read;
		logic [127:0] tok;
		logic [8*128-1:0] line;
		logic [31:0] a;
		logic [31:0] d;
		fetch_pkg::ir_t ir;
		short_read = 1'b0;
		fd = $fopen("testbench/fetch_tests.txt", "r");
		file_ok = (fd != 0);
		if (file_ok)
		begin
			while ($fscanf(fd, "%s", tok) == 1)
			begin
				if (tok == "#")
					code = $fgets(line, fd); // rest of a comment line
				else if (tok == "load")
				begin
					code = $fscanf(fd, "%d", cnt);
					if (code != 1)
						short_read = 1'b1;
					repeat (cnt)
					begin
						code = $fscanf(fd, "%h %h", a, d);
						if (code != 2)
							short_read = 1'b1;
						load_adr[n_load] = a;
						load_dat[n_load] = d;
						n_load++;
					end
				end
				else if (tok == "test")
				begin
					code = $fscanf(fd, "%s %h %h %d %d %d", t_name[n_tests], t_target[n_tests],
						t_mask[n_tests], t_gap[n_tests], ne, nw);
					if (code != 6)
						short_read = 1'b1;
					t_wr_start[n_tests] = n_wr;
					repeat (nw)
					begin
						code = $fscanf(fd, "%h %h", a, d);
						if (code != 2)
							short_read = 1'b1;
						wr_adr[n_wr] = a;
						wr_dat[n_wr] = d;
						n_wr++;
					end
					t_wr_end[n_tests] = n_wr;
					repeat (ne)
					begin
						code = $fscanf(fd, "%h %h", ir, a);
						if (code != 2)
							short_read = 1'b1;
						exp_ir[n_exp] = ir;
						exp_pc[n_exp] = a;
						n_exp++;
					end
					t_exp_end[n_tests] = n_exp;
					cycle_limit += 20 * ne + 100;
					n_tests++;
				end
				else
				begin
					$display("unknown keyword %0s in the tests file", tok);
					parse_bad = 1'b1;
				end
			end
			$fclose(fd);
			if (short_read)
			begin
				$display("the tests file has an entry with missing or malformed fields");
				parse_bad = 1'b1;
			end
		end
	endtask

	task automatic load_program;
		for (int i = 0; i < n_load; i++)
		begin
			@(posedge clk_i);
			load_i <= {1'b1, load_adr[i], load_dat[i]};
		end
		@(posedge clk_i);
		load_i <= '0;
	endtask

	task automatic run_test(input int t);
		int cyc;
		int wr;
		cyc = 0;
		wr = t_wr_start[t];
		@(posedge clk_i);
		pc_set_i <= 1'b1;
		pc_in_i <= t_target[t];
		stall_i <= 1'b0;
		load_i <= '0;
		@(posedge clk_i);
		pc_set_i <= 1'b0;
		cur_name <= t_name[t];
		cur_end <= t_exp_end[t]; // anything shown before this edge is the old path
		while (chk_idx < t_exp_end[t])
		begin
			stall_i <= t_mask[t][cyc % 32] || (($urandom % 8) < t_gap[t]);
			if (cyc[0] && wr < t_wr_end[t])
			begin
				load_i <= {1'b1, wr_adr[wr], wr_dat[wr]}; // a write every other cycle
				wr++;
			end
			else
				load_i <= '0;
			cyc++;
			@(posedge clk_i);
		end
	endtask

	initial
	begin
		clk_i = 1'b0;
		rst_i = 1'b1;
		pc_set_i = 1'b0;
		pc_in_i = '0;
		stall_i = 1'b1; // nothing is popped before the program is loaded
		load_i = '0;
		cur_name = '0;
		cur_end = 0;
		n_load = 0;
		n_wr = 0;
		n_exp = 0;
		n_tests = 0;
		parse_bad = 1'b0;
		cycles = 0;
		cycle_limit = 0;
		void'($urandom(32'hd4d2a8de));
		read_tests();
		if (!file_ok)
		begin
			$display("the tests file testbench/fetch_tests.txt could not be opened");
			$display("SIMULATION FAILED");
			$finish;
		end
		else
		begin
			repeat (10) @(posedge clk_i);
			rst_i <= 1'b0;
			load_program();
			for (int t = 0; t < n_tests; t++)
				run_test(t);
			@(posedge clk_i);
			load_i <= '0;
			$display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
			if (!parse_bad && n_tests > 0 && n_fail == 0 && n_pass == n_tests)
				$display("SIMULATION PASSED");
			else
				$display("SIMULATION FAILED");
			$finish;
		end
	end

endmodule
